/* source/board_pkg.sv */
////////////////////////////////////////
// Shared widths, defaults and counter sizes for the board glue.
// Imported by every RTL block; top level takes its parameter
// defaults from here and passes them down
////////////////////////////////////////

package board_pkg;

  ////////////////////////////////////////
  // SPI host pin widths
  ////////////////////////////////////////

  localparam int unsigned spi_cs_w = 2;
  localparam int unsigned spi_sd_w = 4;

  ////////////////////////////////////////
  // Fan control
  ////////////////////////////////////////

  localparam int unsigned fan_set_w = 4;
  // One PWM period holds one step per setting value
  localparam int unsigned fan_steps = 2 ** fan_set_w;
  localparam int unsigned fan_prescale_default = 4;

  ////////////////////////////////////////
  // Clocking and synchronizers
  ////////////////////////////////////////

  localparam int unsigned sync_stages_default = 2;
  // 10 MHz / (2 * 5) gives a 1 MHz RTC
  localparam int unsigned rtc_half_default = 5;

endpackage

/* source/spi_pad_if.sv */
////////////////////////////////////////
// SPI host pin bundle between the top-level wiring and the SD pads.
// Host side drives clock, selects and data out; pad side returns data in
////////////////////////////////////////

`timescale 1ns/1ns

interface spi_pad_if
  import board_pkg::*;
();

  // Serial clock and its pad enable
  logic                sck;
  logic                sck_en;

  // Chip selects, active low
  logic [spi_cs_w-1:0] csb;
  logic [spi_cs_w-1:0] csb_en;

  // Data lines, one enable per line
  logic [spi_sd_w-1:0] sd_out;
  logic [spi_sd_w-1:0] sd_en;
  logic [spi_sd_w-1:0] sd_in;

  modport host (
    output sck, sck_en, csb, csb_en, sd_out, sd_en,
    input  sd_in
  );

  modport pad (
    input  sck, sck_en, csb, csb_en, sd_out, sd_en,
    output sd_in
  );

endinterface

/* source/reset_sync.sv */
////////////////////////////////////////
// Core reset generator. Board reset and debug reset request assert
// at once and release through a flop chain; test mode hands reset
// straight to the board pin for scan
////////////////////////////////////////

`timescale 1ns/1ns

module reset_sync
  import board_pkg::*;
#(
  parameter int unsigned sync_stages = sync_stages_default
) (
  input  logic clk_10,
  input  logic rst_n,
  input  logic dbg_rst_i,
  input  logic test_mode_i,
  output logic core_rst_no
);

  logic                   arst_n;
  logic [sync_stages-1:0] sync_q;

  // Either source pulls the chain low asynchronously
  assign arst_n = rst_n & ~dbg_rst_i;

  always_ff @(posedge clk_10, negedge arst_n) begin
    if (!arst_n) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= 1'b1;
      for (int i = 1; i < sync_stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Scan bypass
  assign core_rst_no = test_mode_i ? rst_n : sync_q[sync_stages-1];

  // Board reset must always reach the core, test mode or not
  a_board_rst_reaches_core : assert property (
    @(posedge clk_10) !rst_n |-> !core_rst_no
  );

endmodule

/* source/rtc_divider.sv */
////////////////////////////////////////
// Real-time-clock divider. Produces a square wave of
// 2 * rtc_half clk_10 cycles for the timers
////////////////////////////////////////

`timescale 1ns/1ns

module rtc_divider
  import board_pkg::*;
#(
  parameter int unsigned rtc_half = rtc_half_default
) (
  input  logic clk_10,
  input  logic rst_n,
  output logic rtc_clk_o
);

  localparam int unsigned cnt_w = (rtc_half > 1) ? $clog2(rtc_half) : 1;

  logic [cnt_w-1:0] cnt_q;
  logic             wrap;

  assign wrap = (cnt_q == cnt_w'(rtc_half - 1));

  // Counter and output flip together on the wrap
  always_ff @(posedge clk_10, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q     <= '0;
      rtc_clk_o <= 1'b0;
    end else if (wrap) begin
      cnt_q     <= '0;
      rtc_clk_o <= ~rtc_clk_o;
    end else begin
      cnt_q     <= cnt_q + 1'b1;
    end
  end

  // A runaway count would stretch the RTC period
  a_cnt_in_range : assert property (
    @(posedge clk_10) disable iff (!rst_n)
    cnt_q <= cnt_w'(rtc_half - 1)
  );

endmodule

/* source/fan_pwm.sv */
////////////////////////////////////////
// Fan PWM from the board switches. Each period has fan_steps steps
// of fan_prescale cycles; output is high for setting steps
////////////////////////////////////////

`timescale 1ns/1ns

module fan_pwm
  import board_pkg::*;
#(
  parameter int unsigned fan_prescale = fan_prescale_default
) (
  input  logic                 clk_10,
  input  logic                 rst_n,
  input  logic [fan_set_w-1:0] fan_sw_i,
  output logic                 fan_pwm_o
);

  localparam int unsigned pre_w = (fan_prescale > 1) ? $clog2(fan_prescale) : 1;

  logic [fan_set_w-1:0] sw_meta_q;
  logic [fan_set_w-1:0] sw_sync_q;
  logic [pre_w-1:0]     pre_q;
  logic [fan_set_w-1:0] step_q;
  logic [fan_set_w-1:0] set_q;
  logic                 pre_wrap;
  logic                 step_wrap;
  logic                 period_end;

  assign pre_wrap   = (pre_q == pre_w'(fan_prescale - 1));
  assign step_wrap  = (step_q == fan_set_w'(fan_steps - 1));
  assign period_end = pre_wrap & step_wrap;

  ////////////////////////////////////////
  // Switch synchronizer
  ////////////////////////////////////////

  always_ff @(posedge clk_10, negedge rst_n) begin
    if (!rst_n) begin
      sw_meta_q <= '0;
      sw_sync_q <= '0;
    end else begin
      sw_meta_q <= fan_sw_i;
      sw_sync_q <= sw_meta_q;
    end
  end

  ////////////////////////////////////////
  // Step counting and duty compare
  ////////////////////////////////////////

  always_ff @(posedge clk_10, negedge rst_n) begin
    if (!rst_n) begin
      pre_q     <= '0;
      step_q    <= '0;
      set_q     <= '0;
      fan_pwm_o <= 1'b0;
    end else begin
      pre_q <= pre_wrap ? '0 : pre_q + 1'b1;
      if (pre_wrap) begin
        step_q <= step_wrap ? '0 : step_q + 1'b1;
      end
      // New setting takes effect with the next period
      if (period_end) begin
        set_q <= sw_sync_q;
      end
      fan_pwm_o <= (step_q < set_q);
    end
  end

  // Duty may not jump in the middle of a period
  a_set_only_at_boundary : assert property (
    @(posedge clk_10) disable iff (!rst_n)
    (set_q != $past(set_q)) |-> $past(period_end)
  );

endmodule

/* source/sd_pad_adapter.sv */
////////////////////////////////////////
// SPI host to SD-card pads in SPI mode. Pads idle high while
// disabled or while no card sits in the slot
////////////////////////////////////////

`timescale 1ns/1ns

module sd_pad_adapter
  import board_pkg::*;
#(
  parameter int unsigned sync_stages = sync_stages_default
) (
  input  logic       clk_10,
  input  logic       rst_n,
  spi_pad_if.pad     spi,
  input  logic       sd_cd_i,
  input  logic       sd_dat0_i,
  output logic       sd_sclk_o,
  output logic       sd_cmd_o,
  output logic [3:0] sd_dat_o,
  output logic       card_present_o
);

  logic [sync_stages-1:0] cd_q;

  // Card detect switch is active low and asynchronous
  always_ff @(posedge clk_10, negedge rst_n) begin
    if (!rst_n) begin
      cd_q <= '0;
    end else begin
      cd_q[0] <= ~sd_cd_i;
      for (int i = 1; i < sync_stages; i++) begin
        cd_q[i] <= cd_q[i-1];
      end
    end
  end

  assign card_present_o = cd_q[sync_stages-1];

  ////////////////////////////////////////
  // Pad mapping
  ////////////////////////////////////////

  // SCK drives CLK, CS0 drives DAT3, MOSI drives CMD
  assign sd_sclk_o   = (card_present_o & spi.sck_en)    ? spi.sck       : 1'b1;
  assign sd_dat_o[3] = (card_present_o & spi.csb_en[0]) ? spi.csb[0]    : 1'b1;
  assign sd_cmd_o    = (card_present_o & spi.sd_en[0])  ? spi.sd_out[0] : 1'b1;

  // DAT1 and DAT2 unused in SPI mode; DAT0 is an input
  assign sd_dat_o[2:1] = 2'b11;
  assign sd_dat_o[0]   = 1'b1;

  // MISO comes back on data line 1
  always_comb begin
    spi.sd_in    = '0;
    spi.sd_in[1] = sd_dat0_i;
  end

endmodule

/* source/board_glue_top.sv */
////////////////////////////////////////
// Board glue top level with plain pins. Instantiate in the board
// wrapper and connect clk_10 and the SPI host pins of the SoC
////////////////////////////////////////

`timescale 1ns/1ns

module board_glue_top
  import board_pkg::*;
#(
  parameter int unsigned sync_stages  = sync_stages_default,
  parameter int unsigned rtc_half     = rtc_half_default,
  parameter int unsigned fan_prescale = fan_prescale_default
) (
  input  logic                 clk_10,
  input  logic                 rst_n,
  input  logic                 dbg_rst_i,
  input  logic                 test_mode_i,
  // Fan and RTC
  input  logic [fan_set_w-1:0] fan_sw_i,
  output logic                 fan_pwm_o,
  output logic                 rtc_clk_o,
  // SPI host pins
  input  logic                 spi_sck_i,
  input  logic                 spi_sck_en_i,
  input  logic [spi_cs_w-1:0]  spi_csb_i,
  input  logic [spi_cs_w-1:0]  spi_csb_en_i,
  input  logic [spi_sd_w-1:0]  spi_sd_i,
  input  logic [spi_sd_w-1:0]  spi_sd_en_i,
  output logic [spi_sd_w-1:0]  spi_sd_o,
  // SD card pads
  input  logic                 sd_cd_i,
  input  logic                 sd_dat0_i,
  output logic                 sd_sclk_o,
  output logic                 sd_cmd_o,
  output logic [3:0]           sd_dat_o,
  output logic                 card_present_o
);

  logic core_rst_n;

  spi_pad_if spi_bus ();

  // Host side of the bundle
  assign spi_bus.sck    = spi_sck_i;
  assign spi_bus.sck_en = spi_sck_en_i;
  assign spi_bus.csb    = spi_csb_i;
  assign spi_bus.csb_en = spi_csb_en_i;
  assign spi_bus.sd_out = spi_sd_i;
  assign spi_bus.sd_en  = spi_sd_en_i;
  assign spi_sd_o       = spi_bus.sd_in;

  reset_sync #(
    .sync_stages ( sync_stages )
  ) i_reset_sync (
    .clk_10      ( clk_10      ),
    .rst_n       ( rst_n       ),
    .dbg_rst_i   ( dbg_rst_i   ),
    .test_mode_i ( test_mode_i ),
    .core_rst_no ( core_rst_n  )
  );

  rtc_divider #(
    .rtc_half  ( rtc_half   )
  ) i_rtc_divider (
    .clk_10    ( clk_10     ),
    .rst_n     ( core_rst_n ),
    .rtc_clk_o ( rtc_clk_o  )
  );

  fan_pwm #(
    .fan_prescale ( fan_prescale )
  ) i_fan_pwm (
    .clk_10    ( clk_10     ),
    .rst_n     ( core_rst_n ),
    .fan_sw_i  ( fan_sw_i   ),
    .fan_pwm_o ( fan_pwm_o  )
  );

  sd_pad_adapter #(
    .sync_stages    ( sync_stages    )
  ) i_sd_pad_adapter (
    .clk_10         ( clk_10         ),
    .rst_n          ( core_rst_n     ),
    .spi            ( spi_bus.pad    ),
    .sd_cd_i        ( sd_cd_i        ),
    .sd_dat0_i      ( sd_dat0_i      ),
    .sd_sclk_o      ( sd_sclk_o      ),
    .sd_cmd_o       ( sd_cmd_o       ),
    .sd_dat_o       ( sd_dat_o       ),
    .card_present_o ( card_present_o )
  );

endmodule

/* sim/board_checker.sv */
////////////////////////////////////////
// Watches the board glue pins and predicts reset, RTC, fan PWM
// and SD pad behavior. Mismatch count goes back to the testbench
////////////////////////////////////////

`timescale 1ns/1ns

module board_checker
  import board_pkg::*;
#(
  parameter int sync_stages  = 2,
  parameter int rtc_half     = 5,
  parameter int fan_prescale = 4
) (
  input  logic                clk_10,
  input  logic                rst_n,
  input  logic                dbg_rst_i,
  input  logic [fan_set_w-1:0] fan_sw_i,
  input  logic                fan_pwm_o,
  input  logic                rtc_clk_o,
  input  logic                spi_sck_i,
  input  logic                spi_sck_en_i,
  input  logic [spi_cs_w-1:0] spi_csb_i,
  input  logic [spi_cs_w-1:0] spi_csb_en_i,
  input  logic [spi_sd_w-1:0] spi_sd_i,
  input  logic [spi_sd_w-1:0] spi_sd_en_i,
  input  logic [spi_sd_w-1:0] spi_sd_o,
  input  logic                sd_cd_i,
  input  logic                sd_dat0_i,
  input  logic                sd_sclk_o,
  input  logic                sd_cmd_o,
  input  logic [3:0]          sd_dat_o,
  input  logic                card_present_o,
  output int                  err_cnt_o,
  output int                  win_cnt_o
);

  localparam int period = int'(fan_steps) * fan_prescale;

  int                   err_cnt  = 0;
  int                   win_cnt  = 0;
  int                   rel_cnt  = 0;
  int                   cd_cnt   = 0;
  int                   sw_cnt   = 0;
  int                   rtc_run  = 0;
  int                   pwm_len  = 0;
  int                   pwm_high = 0;
  logic                 rtc_seen = 1'b0;
  logic                 rtc_late = 1'b0;
  logic                 pwm_seen = 1'b0;
  logic                 rtc_prev = 1'b0;
  logic                 pwm_prev = 1'b0;
  logic                 cd_prev  = 1'b0;
  logic [fan_set_w-1:0] sw_prev  = '0;
  logic                 in_reset;
  logic                 card_exp;
  logic                 card_known;

  assign err_cnt_o = err_cnt;
  assign win_cnt_o = win_cnt;

  // High cycles in one PWM period
  function automatic int expected_high(input logic [fan_set_w-1:0] setting);
    return int'(setting) * fan_prescale;
  endfunction

  // Pads as {sclk, cmd, dat[3:0]}, idle high unless card and enable
  function automatic logic [5:0] expected_pads(
    input logic card,
    input logic sck,
    input logic sck_en,
    input logic csb0,
    input logic csb_en0,
    input logic mosi,
    input logic mosi_en
  );
    logic [5:0] pads;
    pads = 6'b11_1111;
    if (card && sck_en) pads[5] = sck;
    if (card && mosi_en) pads[4] = mosi;
    if (card && csb_en0) pads[3] = csb0;
    return pads;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp_v, act_v);
    err_cnt++;
  endtask

  always @(negedge clk_10) begin
    in_reset = !rst_n || dbg_rst_i;
    if (in_reset) rel_cnt = -1;
    else rel_cnt++;
    if (sd_cd_i != cd_prev) cd_cnt = 0;
    else cd_cnt++;
    if (fan_sw_i != sw_prev) sw_cnt = 0;
    else sw_cnt++;

    if (in_reset && (rtc_clk_o || fan_pwm_o || card_present_o)) begin
      report_mismatch("{rtc_clk_o,fan_pwm_o,card_present_o} in reset", 0,
                      32'({rtc_clk_o, fan_pwm_o, card_present_o}));
    end

    ////////////////////////////////////////
    // RTC level lengths and restart
    ////////////////////////////////////////
    if (in_reset) begin
      rtc_seen = 1'b0;
      rtc_late = 1'b0;
    end else if (rtc_clk_o != rtc_prev) begin
      if (rtc_seen && rtc_run != rtc_half) begin
        report_mismatch("rtc_clk_o level length", rtc_half, rtc_run);
      end
      // Internal release may land anywhere in sync_stages+1 cycles
      if (!rtc_seen && (rel_cnt <= rtc_half || rel_cnt > rtc_half + sync_stages + 1)) begin
        report_mismatch("rtc_clk_o first toggle cycle", rtc_half + sync_stages, rel_cnt);
      end
      rtc_seen = 1'b1;
      rtc_run  = 1;
    end else begin
      rtc_run++;
      if (!rtc_seen && !rtc_late && rel_cnt > rtc_half + sync_stages + 1) begin
        $display("At %0t ns the RTC did not start after reset release", $time);
        err_cnt++;
        rtc_late = 1'b1;
      end
    end

    ////////////////////////////////////////
    // PWM windows, rise to rise
    ////////////////////////////////////////
    if (in_reset) begin
      pwm_seen = 1'b0;
    end else if (fan_pwm_o && !pwm_prev) begin
      // Only windows that saw one setting from start to end
      if (pwm_seen && sw_cnt >= period + 8) begin
        if (pwm_len != period) report_mismatch("fan_pwm_o period", period, pwm_len);
        if (pwm_high != expected_high(fan_sw_i)) begin
          report_mismatch("fan_pwm_o high cycles", expected_high(fan_sw_i), pwm_high);
        end
        win_cnt++;
      end
      pwm_seen = 1'b1;
      pwm_len  = 1;
      pwm_high = 1;
    end else begin
      pwm_len++;
      if (fan_pwm_o) pwm_high++;
    end
    if (fan_sw_i == '0 && sw_cnt >= period + 8 && fan_pwm_o) begin
      report_mismatch("fan_pwm_o at setting 0", 0, 1);
    end

    ////////////////////////////////////////
    // Card detect and SD pads
    ////////////////////////////////////////
    card_exp   = !in_reset && !sd_cd_i;
    card_known = in_reset || (rel_cnt > 2 * sync_stages && cd_cnt > sync_stages);
    if (card_known) begin
      if (card_present_o != card_exp) begin
        report_mismatch("card_present_o", 32'(card_exp), 32'(card_present_o));
      end
      if ({sd_sclk_o, sd_cmd_o, sd_dat_o} != expected_pads(card_exp, spi_sck_i,
          spi_sck_en_i, spi_csb_i[0], spi_csb_en_i[0], spi_sd_i[0], spi_sd_en_i[0])) begin
        report_mismatch("{sd_sclk_o,sd_cmd_o,sd_dat_o}",
                        32'(expected_pads(card_exp, spi_sck_i, spi_sck_en_i, spi_csb_i[0],
                            spi_csb_en_i[0], spi_sd_i[0], spi_sd_en_i[0])),
                        32'({sd_sclk_o, sd_cmd_o, sd_dat_o}));
      end
    end
    // MISO loop-back into bit 1
    if (spi_sd_o != spi_sd_w'({sd_dat0_i, 1'b0})) begin
      report_mismatch("spi_sd_o", 32'(spi_sd_w'({sd_dat0_i, 1'b0})), 32'(spi_sd_o));
    end

    rtc_prev = rtc_clk_o;
    pwm_prev = fan_pwm_o;
    cd_prev  = sd_cd_i;
    sw_prev  = fan_sw_i;
  end

endmodule

/* sim/tb_board_glue.sv */
////////////////////////////////////////
// Board glue testbench. Drives reset, fan switches and random
// SPI pins; board_checker compares the DUT pins
////////////////////////////////////////

`timescale 1ns/1ns

module tb_board_glue
  import board_pkg::*;
();

  localparam int period = fan_steps * fan_prescale_default;

  logic                 clk_10;
  logic                 rst_n;
  logic                 dbg_rst_i;
  logic                 test_mode_i;
  logic [fan_set_w-1:0] fan_sw_i;
  logic                 fan_pwm_o;
  logic                 rtc_clk_o;
  logic                 spi_sck_i;
  logic                 spi_sck_en_i;
  logic [spi_cs_w-1:0]  spi_csb_i;
  logic [spi_cs_w-1:0]  spi_csb_en_i;
  logic [spi_sd_w-1:0]  spi_sd_i;
  logic [spi_sd_w-1:0]  spi_sd_en_i;
  logic [spi_sd_w-1:0]  spi_sd_o;
  logic                 sd_cd_i;
  logic                 sd_dat0_i;
  logic                 sd_sclk_o;
  logic                 sd_cmd_o;
  logic [3:0]           sd_dat_o;
  logic                 card_present_o;
  int                   check_errs;
  int                   pwm_windows;
  int                   fail_cnt;
  int unsigned          seed_ret;

  board_glue_top #(
    .sync_stages  ( sync_stages_default  ),
    .rtc_half     ( rtc_half_default     ),
    .fan_prescale ( fan_prescale_default )
  ) uut (.*);

  board_checker #(
    .sync_stages  ( sync_stages_default  ),
    .rtc_half     ( rtc_half_default     ),
    .fan_prescale ( fan_prescale_default )
  ) chk (
    .err_cnt_o ( check_errs  ),
    .win_cnt_o ( pwm_windows ),
    .*
  );

  initial begin
    clk_10 = 1'b0;
    forever #4 clk_10 = ~clk_10;
  end

  // New random SPI pins and card data line
  task automatic drive_random_pins();
    spi_sck_i    = 1'($urandom());
    spi_sck_en_i = 1'($urandom());
    spi_csb_i    = spi_cs_w'($urandom());
    spi_csb_en_i = spi_cs_w'($urandom());
    spi_sd_i     = spi_sd_w'($urandom());
    spi_sd_en_i  = spi_sd_w'($urandom());
    sd_dat0_i    = 1'($urandom());
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      @(posedge clk_10);
      #1;
      drive_random_pins();
    end
  endtask

  task automatic wait_card(input logic level, input int limit);
    int n;
    n = 0;
    while (card_present_o !== level && n < limit) begin
      @(posedge clk_10);
      #1;
      n++;
    end
    if (card_present_o !== level) begin
      $display("Timeout: card_present_o did not reach %0b within %0d cycles", level, limit);
      fail_cnt++;
    end
  endtask

  initial begin
    seed_ret    = $urandom(32'h4ff8_b0c5);
    fail_cnt    = 0;
    rst_n       = 1'b0;
    dbg_rst_i   = 1'b0;
    test_mode_i = 1'b0;
    fan_sw_i    = '0;
    sd_cd_i     = 1'b0;
    drive_random_pins();
    repeat (5) @(posedge clk_10);
    #1;
    rst_n = 1'b1;
    wait_card(1'b1, 20);

    // Duty sweep, setting 0 first, three periods each
    for (int i = 0; i < 6; i++) begin
      fan_sw_i = (i == 0) ? '0 : fan_set_w'($urandom_range(fan_steps - 1, 1));
      run_cycles(3 * period);
    end

    // Debug reset pulse mid-run
    dbg_rst_i = 1'b1;
    run_cycles(3);
    dbg_rst_i = 1'b0;
    wait_card(1'b1, 20);
    run_cycles(40);

    // Card removal
    sd_cd_i = 1'b1;
    wait_card(1'b0, 20);
    run_cycles(30);

    if (pwm_windows == 0) begin
      $display("No complete PWM period was checked");
      fail_cnt++;
    end
    $display("Errors: %0d mismatches, %0d other failures", check_errs, fail_cnt);
    if (check_errs == 0 && fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* files.f */
source/board_pkg.sv
source/spi_pad_if.sv
source/reset_sync.sv
source/rtc_divider.sv
source/fan_pwm.sv
source/sd_pad_adapter.sv
source/board_glue_top.sv
sim/board_checker.sv
sim/tb_board_glue.sv

/* Makefile */
# Verilator lint and simulation of the board glue testbench

VERILATOR  = verilator
TOP        = tb_board_glue
FILELIST   = files.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Done: no errors
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -Mdir $(OBJ_DIR)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
